/* axi_decerr_resp.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

module axi_decerr_resp (
    input  wire                            axi_m,
    input  wire                            rst_n,
    input  wire axi_lite_demux_pkg::aw_req_s err_aw,
    input  wire axi_lite_demux_pkg::w_req_s  err_w,
    input  wire axi_lite_demux_pkg::ar_req_s err_ar,
    input  wire                            mgr_bready,
    input  wire                            mgr_rready,
    output logic                           err_awready,
    output logic                           err_wready,
    output axi_lite_demux_pkg::b_rsp_s     err_b,
    output logic                           err_arready,
    output axi_lite_demux_pkg::r_rsp_s     err_r
);
    import axi_lite_demux_pkg::*;

    err_state_e wr_state;
    err_state_e rd_state;

    ////////////////////
    // Write side
    // Data may arrive with the address or any cycle after it
    assign err_awready = (wr_state == IDLE);
    assign err_wready  = (wr_state == WAIT_W) || ((wr_state == IDLE) && err_aw.awvalid);

    always_ff @(posedge axi_m or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= IDLE;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (err_aw.awvalid) begin
                        wr_state <= err_w.wvalid ? RESP : WAIT_W;
                    end
                end
                WAIT_W: begin
                    if (err_w.wvalid) begin
                        wr_state <= RESP;
                    end
                end
                RESP: begin
                    if (mgr_bready) begin
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // Read side, no data phase
    assign err_arready = (rd_state == IDLE);

    always_ff @(posedge axi_m or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= IDLE;
        end else if (rd_state == IDLE && err_ar.arvalid) begin
            rd_state <= RESP;
        end else if (rd_state == RESP && mgr_rready) begin
            rd_state <= IDLE;
        end
    end

    always_comb begin
        err_b.bvalid = (wr_state == RESP);
        err_b.bresp  = DECERR;
        err_r.rvalid = (rd_state == RESP);
        err_r.rdata  = '0;
        err_r.rresp  = DECERR;
    end

endmodule

`default_nettype wire

/* axi_lite_demux.f */
+incdir+.
axi_lite_demux_pkg.sv
axi_slot_decode.sv
axi_wr_route.sv
axi_rd_route.sv
axi_decerr_resp.sv
axi_lite_demux.sv
tb_axi_lite_demux.sv

/* axi_lite_demux.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

module axi_lite_demux (
    input  wire                                           axi_m,
    input  wire                                           rst_n,
    // Manager side
    input  wire axi_lite_demux_pkg::aw_req_s                mgr_aw,
    input  wire axi_lite_demux_pkg::w_req_s                 mgr_w,
    input  wire axi_lite_demux_pkg::ar_req_s                mgr_ar,
    input  wire                                           mgr_bready,
    input  wire                                           mgr_rready,
    output logic                                          mgr_awready,
    output logic                                          mgr_wready,
    output axi_lite_demux_pkg::b_rsp_s                      mgr_b,
    output logic                                          mgr_arready,
    output axi_lite_demux_pkg::r_rsp_s                      mgr_r,
    // Subordinate side
    output axi_lite_demux_pkg::aw_req_s [`NUM_SUB-1:0]      sub_aw,
    output axi_lite_demux_pkg::w_req_s [`NUM_SUB-1:0]       sub_w,
    output axi_lite_demux_pkg::ar_req_s [`NUM_SUB-1:0]      sub_ar,
    output logic [`NUM_SUB-1:0]                           sub_bready,
    output logic [`NUM_SUB-1:0]                           sub_rready,
    input  wire [`NUM_SUB-1:0]                            sub_awready,
    input  wire [`NUM_SUB-1:0]                            sub_wready,
    input  wire [`NUM_SUB-1:0]                            sub_arready,
    input  wire axi_lite_demux_pkg::b_rsp_s [`NUM_SUB-1:0]  sub_b,
    input  wire axi_lite_demux_pkg::r_rsp_s [`NUM_SUB-1:0]  sub_r
);
    import axi_lite_demux_pkg::*;

    slot_sel_s wr_sel;
    slot_sel_s rd_sel;
    logic      wr_done;
    logic      rd_done;
    aw_req_s   err_aw;
    w_req_s    err_w;
    ar_req_s   err_ar;
    logic      err_awready;
    logic      err_wready;
    logic      err_arready;
    b_rsp_s    err_b;
    r_rsp_s    err_r;

    axi_slot_decode u_decode (
        .axi_m(axi_m), .rst_n(rst_n), .mgr_aw(mgr_aw), .mgr_ar(mgr_ar),
        .mgr_awready(mgr_awready), .mgr_arready(mgr_arready),
        .wr_done(wr_done), .rd_done(rd_done), .wr_sel(wr_sel), .rd_sel(rd_sel)
    );

    axi_wr_route u_wr_route (
        .axi_m(axi_m), .rst_n(rst_n), .wr_sel(wr_sel), .mgr_aw(mgr_aw), .mgr_w(mgr_w),
        .mgr_bready(mgr_bready), .sub_awready(sub_awready), .sub_wready(sub_wready),
        .sub_b(sub_b), .err_awready(err_awready), .err_wready(err_wready), .err_b(err_b),
        .sub_aw(sub_aw), .sub_w(sub_w), .sub_bready(sub_bready), .err_aw(err_aw),
        .err_w(err_w), .mgr_awready(mgr_awready), .mgr_wready(mgr_wready),
        .mgr_b(mgr_b), .wr_done(wr_done)
    );

    axi_rd_route u_rd_route (
        .rd_sel(rd_sel), .mgr_ar(mgr_ar), .mgr_rready(mgr_rready),
        .sub_arready(sub_arready), .sub_r(sub_r), .err_arready(err_arready),
        .err_r(err_r), .sub_ar(sub_ar), .sub_rready(sub_rready), .err_ar(err_ar),
        .mgr_arready(mgr_arready), .mgr_r(mgr_r), .rd_done(rd_done)
    );

    axi_decerr_resp u_decerr (
        .axi_m(axi_m), .rst_n(rst_n), .err_aw(err_aw), .err_w(err_w), .err_ar(err_ar),
        .mgr_bready(mgr_bready), .mgr_rready(mgr_rready), .err_awready(err_awready),
        .err_wready(err_wready), .err_b(err_b), .err_arready(err_arready), .err_r(err_r)
    );

endmodule

`default_nettype wire

/* axi_lite_demux_defs.svh */
`ifndef AXI_LITE_DEMUX_DEFS_SVH
`define AXI_LITE_DEMUX_DEFS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W (`DATA_W / 8)

// Slot count and window size in address bits
`define NUM_SUB 4
`define WIN_W 4

// Slot base addresses, 16 bytes apart
`define SUB0_BASE 32'h0000_0000
`define SUB1_BASE 32'h0000_0010
`define SUB2_BASE 32'h0000_0020
`define SUB3_BASE 32'h0000_0030

// Slot 2 is off, its range answers DECERR
`define SUB_EN_MASK 4'b1011

`endif

/* axi_lite_demux_pkg.sv */
`default_nettype none
`include "axi_lite_demux_defs.svh"

package axi_lite_demux_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    ////////////////////
    // Channel payloads, valid in the top bit
    typedef struct packed {
        logic              awvalid;
        logic [`ADDR_W-1:0] awaddr;
        logic [2:0]        awprot;
    } aw_req_s;

    typedef struct packed {
        logic              wvalid;
        logic [`DATA_W-1:0] wdata;
        logic [`STRB_W-1:0] wstrb;
    } w_req_s;

    typedef struct packed {
        logic      bvalid;
        axi_resp_e bresp;
    } b_rsp_s;

    typedef struct packed {
        logic              arvalid;
        logic [`ADDR_W-1:0] araddr;
        logic [2:0]        arprot;
    } ar_req_s;

    typedef struct packed {
        logic              rvalid;
        logic [`DATA_W-1:0] rdata;
        axi_resp_e         rresp;
    } r_rsp_s;

    ////////////////////
    // Routing selection
    typedef logic [$clog2(`NUM_SUB)-1:0] slot_idx_t;

    typedef struct packed {
        logic      valid;
        logic      unmapped;
        slot_idx_t idx;
    } slot_sel_s;

    typedef enum logic [1:0] {IDLE, WAIT_W, RESP} err_state_e;

endpackage

`default_nettype wire

/* axi_lite_demux_testdata.txt */
// op addr wdata wstrb, one access per line, all hex
// op 0 write, 1 read, 2 write with bready stall, 3 read with rready stall, 4 write with next read
0 00000000 11223344 f
1 00000000 00000000 0
0 00000014 a5a55a5a f
1 00000014 00000000 0
0 0000003c cafef00d f
1 0000003c 00000000 0
0 00000014 000000ee 1
1 00000014 00000000 0
0 00000008 bbcc0000 c
1 00000008 00000000 0
0 00000024 12345678 f
1 00000028 00000000 0
0 00000040 87654321 f
1 00000100 00000000 0
2 00000004 0badcafe f
3 00000004 00000000 0
2 00000044 00000001 f
3 0000002c 00000000 0
4 00000030 5555aaaa f
1 00000000 00000000 0
4 00000018 76543210 3
1 0000003c 00000000 0
1 00000030 00000000 0
1 00000018 00000000 0

/* axi_rd_route.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

module axi_rd_route (
    input  wire axi_lite_demux_pkg::slot_sel_s              rd_sel,
    input  wire axi_lite_demux_pkg::ar_req_s                mgr_ar,
    input  wire                                           mgr_rready,
    input  wire [`NUM_SUB-1:0]                            sub_arready,
    input  wire axi_lite_demux_pkg::r_rsp_s [`NUM_SUB-1:0]  sub_r,
    input  wire                                           err_arready,
    input  wire axi_lite_demux_pkg::r_rsp_s                 err_r,
    output axi_lite_demux_pkg::ar_req_s [`NUM_SUB-1:0]      sub_ar,
    output logic [`NUM_SUB-1:0]                           sub_rready,
    output axi_lite_demux_pkg::ar_req_s                     err_ar,
    output logic                                          mgr_arready,
    output axi_lite_demux_pkg::r_rsp_s                      mgr_r,
    output logic                                          rd_done
);

    logic [`NUM_SUB-1:0] slot_on;

    // Decoded slot, also used outside the address phase
    always_comb begin
        for (int i = 0; i < `NUM_SUB; i++) begin
            slot_on[i] = !rd_sel.unmapped && (rd_sel.idx == i);
        end
    end

    ////////////////////
    // Fan-out of the read address
    always_comb begin
        for (int i = 0; i < `NUM_SUB; i++) begin
            sub_ar[i]         = mgr_ar;
            sub_ar[i].arvalid = mgr_ar.arvalid && rd_sel.valid && slot_on[i];
        end
        err_ar         = mgr_ar;
        err_ar.arvalid = mgr_ar.arvalid && rd_sel.valid && rd_sel.unmapped;
    end

    assign sub_rready = slot_on & {`NUM_SUB{mgr_rready}};

    ////////////////////
    // Read data back to the manager
    // Unmapped reads take the error responder's zero data
    assign mgr_arready = rd_sel.valid &&
                         (rd_sel.unmapped ? err_arready : sub_arready[rd_sel.idx]);
    assign mgr_r       = rd_sel.unmapped ? err_r : sub_r[rd_sel.idx];
    assign rd_done     = mgr_r.rvalid && mgr_rready;

endmodule

`default_nettype wire

/* axi_slot_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

module axi_slot_decode (
    input  wire                            axi_m,
    input  wire                            rst_n,
    input  wire axi_lite_demux_pkg::aw_req_s mgr_aw,
    input  wire axi_lite_demux_pkg::ar_req_s mgr_ar,
    input  wire                            mgr_awready,
    input  wire                            mgr_arready,
    input  wire                            wr_done,
    input  wire                            rd_done,
    output axi_lite_demux_pkg::slot_sel_s  wr_sel,
    output axi_lite_demux_pkg::slot_sel_s  rd_sel
);
    import axi_lite_demux_pkg::*;

    localparam logic [`NUM_SUB-1:0][`ADDR_W-1:0] sub_base =
        {`SUB3_BASE, `SUB2_BASE, `SUB1_BASE, `SUB0_BASE};
    localparam logic [`NUM_SUB-1:0] sub_en = `SUB_EN_MASK;

    // Enabled slots whose window holds the address
    function automatic logic [`NUM_SUB-1:0] window_hits(input logic [`ADDR_W-1:0] addr);
        logic [`NUM_SUB-1:0] hits;
        for (int i = 0; i < `NUM_SUB; i++) begin
            hits[i] = sub_en[i] &&
                (addr[`ADDR_W-1:`WIN_W] == sub_base[i][`ADDR_W-1:`WIN_W]);
        end
        return hits;
    endfunction

    // One-hot hits to slot index, no hit means unmapped
    function automatic slot_sel_s to_sel(input logic [`NUM_SUB-1:0] hits,
                                         input logic addr_open);
        slot_sel_s sel;
        sel.valid    = addr_open;
        sel.unmapped = ~|hits;
        sel.idx      = '0;
        for (int i = 0; i < `NUM_SUB; i++) begin
            if (hits[i]) begin
                sel.idx = slot_idx_t'(i);
            end
        end
        return sel;
    endfunction

    logic [`NUM_SUB-1:0] wr_hits;
    logic [`NUM_SUB-1:0] rd_hits;
    slot_sel_s           wr_hold;
    slot_sel_s           rd_hold;
    logic                wr_busy;
    logic                rd_busy;

    assign wr_hits = window_hits(mgr_aw.awaddr);
    assign rd_hits = window_hits(mgr_ar.araddr);

    // Live decode while idle, held slot with the address phase closed after
    assign wr_sel = wr_busy ? wr_hold : to_sel(wr_hits, mgr_aw.awvalid);
    assign rd_sel = rd_busy ? rd_hold : to_sel(rd_hits, mgr_ar.arvalid);

    always_ff @(posedge axi_m or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
            wr_hold <= '0;
        end else if (wr_done) begin
            wr_busy <= 1'b0;
        end else if (mgr_aw.awvalid && mgr_awready) begin
            wr_busy <= 1'b1;
            wr_hold <= to_sel(wr_hits, 1'b0);
        end
    end

    always_ff @(posedge axi_m or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            rd_hold <= '0;
        end else if (rd_done) begin
            rd_busy <= 1'b0;
        end else if (mgr_ar.arvalid && mgr_arready) begin
            rd_busy <= 1'b1;
            rd_hold <= to_sel(rd_hits, 1'b0);
        end
    end

    // A second address handshake would overwrite the held slot
    assert property (@(posedge axi_m) disable iff (!rst_n)
        !(wr_busy && mgr_aw.awvalid && mgr_awready) &&
        !(rd_busy && mgr_ar.arvalid && mgr_arready))
        else $error("address accepted while a transaction is outstanding");

endmodule

`default_nettype wire

/* axi_wr_route.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

module axi_wr_route (
    input  wire                                           axi_m,
    input  wire                                           rst_n,
    input  wire axi_lite_demux_pkg::slot_sel_s              wr_sel,
    input  wire axi_lite_demux_pkg::aw_req_s                mgr_aw,
    input  wire axi_lite_demux_pkg::w_req_s                 mgr_w,
    input  wire                                           mgr_bready,
    input  wire [`NUM_SUB-1:0]                            sub_awready,
    input  wire [`NUM_SUB-1:0]                            sub_wready,
    input  wire axi_lite_demux_pkg::b_rsp_s [`NUM_SUB-1:0]  sub_b,
    input  wire                                           err_awready,
    input  wire                                           err_wready,
    input  wire axi_lite_demux_pkg::b_rsp_s                 err_b,
    output axi_lite_demux_pkg::aw_req_s [`NUM_SUB-1:0]      sub_aw,
    output axi_lite_demux_pkg::w_req_s [`NUM_SUB-1:0]       sub_w,
    output logic [`NUM_SUB-1:0]                           sub_bready,
    output axi_lite_demux_pkg::aw_req_s                     err_aw,
    output axi_lite_demux_pkg::w_req_s                      err_w,
    output logic                                          mgr_awready,
    output logic                                          mgr_wready,
    output axi_lite_demux_pkg::b_rsp_s                      mgr_b,
    output logic                                          wr_done
);

    ////////////////////
    // Fan-out, only valids and bready are gated
    always_comb begin
        for (int i = 0; i < `NUM_SUB; i++) begin
            sub_aw[i]         = mgr_aw;
            sub_w[i]          = mgr_w;
            sub_aw[i].awvalid = mgr_aw.awvalid && wr_sel.valid && !wr_sel.unmapped
                                && (wr_sel.idx == i);
            sub_w[i].wvalid   = mgr_w.wvalid && !wr_sel.unmapped && (wr_sel.idx == i);
            sub_bready[i]     = mgr_bready && !wr_sel.unmapped && (wr_sel.idx == i);
        end
        err_aw         = mgr_aw;
        err_aw.awvalid = mgr_aw.awvalid && wr_sel.valid && wr_sel.unmapped;
        err_w          = mgr_w;
        err_w.wvalid   = mgr_w.wvalid && wr_sel.unmapped;
    end

    ////////////////////
    // Return path from the selected slot
    assign mgr_awready = wr_sel.valid &&
                         (wr_sel.unmapped ? err_awready : sub_awready[wr_sel.idx]);
    assign mgr_wready  = wr_sel.unmapped ? err_wready : sub_wready[wr_sel.idx];
    assign mgr_b       = wr_sel.unmapped ? err_b : sub_b[wr_sel.idx];
    assign wr_done     = mgr_b.bvalid && mgr_bready;

    // Held selection keeps a stalled response on the same source
    assert property (@(posedge axi_m) disable iff (!rst_n)
        mgr_b.bvalid && !mgr_bready |=> mgr_b.bvalid && $stable(mgr_b))
        else $error("write response changed while stalled");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_axi_lite_demux \
    -f axi_lite_demux.f -o Vtb_axi_lite_demux \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_axi_lite_demux)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_axi_lite_demux.sv */
`timescale 1ns/1ns
`default_nettype none
`include "axi_lite_demux_defs.svh"

// Subordinate with four words of memory and random handshake delays
module sub_model (
    input  wire                              axi_m,
    input  wire axi_lite_demux_pkg::aw_req_s aw,
    input  wire axi_lite_demux_pkg::w_req_s  w,
    input  wire axi_lite_demux_pkg::ar_req_s ar,
    input  wire                              bready,
    input  wire                              rready,
    output logic                             awready,
    output logic                             wready,
    output logic                             arready,
    output axi_lite_demux_pkg::b_rsp_s       b,
    output axi_lite_demux_pkg::r_rsp_s       r
);
    import axi_lite_demux_pkg::*;

    logic [`DATA_W-1:0] mem [4];

    // Move n clock edges, landing just after the last one
    task automatic step(input int unsigned n);
        repeat (n) begin
            @(posedge axi_m);
            #2;
        end
    endtask

    initial begin
        logic [1:0] idx;
        awready = 1'b0;
        wready  = 1'b0;
        b       = '0;
        for (int i = 0; i < 4; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(negedge axi_m);
            if (aw.awvalid) begin
                idx = aw.awaddr[3:2];
                step(1 + $urandom_range(3));
                awready = 1'b1;
                step(1);
                awready = 1'b0;
                @(negedge axi_m);
                while (!w.wvalid) @(negedge axi_m);
                // Byte merge by strobe
                for (int k = 0; k < `STRB_W; k++) begin
                    if (w.wstrb[k]) mem[idx][8*k +: 8] = w.wdata[8*k +: 8];
                end
                step(1 + $urandom_range(3));
                wready = 1'b1;
                step(1);
                wready = 1'b0;
                step($urandom_range(3));
                b = '{bvalid: 1'b1, bresp: OKAY};
                @(negedge axi_m);
                while (!bready) @(negedge axi_m);
                step(1);
                b = '0;
            end
        end
    end

    initial begin
        logic [1:0] idx;
        arready = 1'b0;
        r       = '0;
        forever begin
            @(negedge axi_m);
            if (ar.arvalid) begin
                idx = ar.araddr[3:2];
                step(1 + $urandom_range(3));
                arready = 1'b1;
                step(1);
                arready = 1'b0;
                step($urandom_range(3));
                r = '{rvalid: 1'b1, rdata: mem[idx], rresp: OKAY};
                @(negedge axi_m);
                while (!rready) @(negedge axi_m);
                step(1);
                r = '0;
            end
        end
    end

endmodule

module tb_axi_lite_demux;
    import axi_lite_demux_pkg::*;

    localparam int MAX_ACC = 64;

    logic                   axi_m;
    logic                   rst_n;
    aw_req_s                mgr_aw;
    w_req_s                 mgr_w;
    ar_req_s                mgr_ar;
    logic                   mgr_bready, mgr_rready;
    logic                   mgr_awready, mgr_wready, mgr_arready;
    b_rsp_s                 mgr_b;
    r_rsp_s                 mgr_r;
    aw_req_s [`NUM_SUB-1:0] sub_aw;
    w_req_s  [`NUM_SUB-1:0] sub_w;
    ar_req_s [`NUM_SUB-1:0] sub_ar;
    logic [`NUM_SUB-1:0]    sub_bready, sub_rready;
    wire [`NUM_SUB-1:0]     sub_awready, sub_wready, sub_arready;
    wire b_rsp_s [`NUM_SUB-1:0] sub_b;
    wire r_rsp_s [`NUM_SUB-1:0] sub_r;

    logic [31:0]        stim [MAX_ACC*4];
    logic [`DATA_W-1:0] ref_mem [16];
    int                 num_acc;
    int                 errors;
    int                 sub_valids;

    axi_lite_demux DUT (.*);

    for (genvar g = 0; g < `NUM_SUB; g++) begin : g_sub
        sub_model u_sub (
            .axi_m(axi_m), .aw(sub_aw[g]), .w(sub_w[g]), .ar(sub_ar[g]),
            .bready(sub_bready[g]), .rready(sub_rready[g]), .awready(sub_awready[g]),
            .wready(sub_wready[g]), .arready(sub_arready[g]), .b(sub_b[g]), .r(sub_r[g])
        );
    end

    always #10 axi_m = ~axi_m;

    // Valids that reach any subordinate, for the unmapped checks
    always @(negedge axi_m) begin
        for (int i = 0; i < `NUM_SUB; i++) begin
            if (sub_aw[i].awvalid || sub_w[i].wvalid || sub_ar[i].arvalid) begin
                sub_valids = sub_valids + 1;
            end
            // Payload fields reach every slot unchanged
            if (rst_n) begin
                check("sub_aw fields", 64'({sub_aw[i].awaddr, sub_aw[i].awprot}),
                      64'({mgr_aw.awaddr, mgr_aw.awprot}));
                check("sub_w fields", 64'({sub_w[i].wdata, sub_w[i].wstrb}),
                      64'({mgr_w.wdata, mgr_w.wstrb}));
                check("sub_ar fields", 64'({sub_ar[i].araddr, sub_ar[i].arprot}),
                      64'({mgr_ar.araddr, mgr_ar.arprot}));
            end
        end
    end

    ////////////////////
    // Checking and reference model
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Enabled slot whose 16-byte window holds the address
    function automatic logic is_mapped(input logic [`ADDR_W-1:0] addr);
        logic [`NUM_SUB-1:0] en;
        logic [`ADDR_W-1:0]  slot;
        en   = `SUB_EN_MASK;
        slot = addr >> `WIN_W;
        return (slot < `NUM_SUB) && en[slot[1:0]];
    endfunction

    // Same offset in the neighbouring window
    function automatic logic [`ADDR_W-1:0] neighbor_addr(input logic [`ADDR_W-1:0] addr);
        return addr ^ (`ADDR_W'(1) << `WIN_W);
    endfunction

    function automatic logic [`DATA_W-1:0] strb_mask(input logic [`STRB_W-1:0] strb);
        logic [`DATA_W-1:0] mask;
        for (int i = 0; i < `STRB_W; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    ////////////////////
    // Manager driver, starts and ends just after a rising edge
    task automatic write_access(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
                                input logic [`STRB_W-1:0] strb, input int stall);
        logic      aw_now, w_now;
        axi_resp_e exp_resp;
        b_rsp_s    held;
        int        base;
        exp_resp = DECERR;
        if (is_mapped(addr)) begin
            exp_resp = OKAY;
            ref_mem[addr[5:2]] = (ref_mem[addr[5:2]] & ~strb_mask(strb))
                                 | (data & strb_mask(strb));
        end
        base       = sub_valids;
        mgr_aw     = '{awvalid: 1'b1, awaddr: addr, awprot: 3'b010};
        mgr_w      = '{wvalid: 1'b1, wdata: data, wstrb: strb};
        mgr_bready = (stall == 0);
        while (mgr_aw.awvalid || mgr_w.wvalid) begin
            @(negedge axi_m);
            aw_now = mgr_aw.awvalid && mgr_awready;
            w_now  = mgr_w.wvalid && mgr_wready;
            @(posedge axi_m);
            #2;
            if (aw_now) mgr_aw.awvalid = 1'b0;
            if (w_now) mgr_w.wvalid = 1'b0;
        end
        @(negedge axi_m);
        while (!mgr_b.bvalid) @(negedge axi_m);
        held = mgr_b;
        // Stalled response must hold, and a write queued to the next window waits
        if (stall > 0) begin
            @(posedge axi_m);
            #2 mgr_aw = '{awvalid: 1'b1, awaddr: neighbor_addr(addr), awprot: 3'b010};
            repeat (stall) begin
                @(negedge axi_m);
                check("mgr_b", 64'(mgr_b), 64'(held));
                check("mgr_awready", 64'(mgr_awready), 64'h0);
            end
            @(posedge axi_m);
            #2 mgr_bready = 1'b1;
        end
        @(posedge axi_m);
        #2 mgr_bready = 1'b0;
        check("bresp", 64'(held.bresp), 64'(exp_resp));
        if (exp_resp == DECERR) check("sub valid count", 64'(sub_valids), 64'(base));
    endtask

    task automatic read_access(input logic [`ADDR_W-1:0] addr, input int stall);
        logic [`DATA_W-1:0] exp_data;
        axi_resp_e          exp_resp;
        r_rsp_s             held;
        int                 base;
        exp_resp = is_mapped(addr) ? OKAY : DECERR;
        exp_data = is_mapped(addr) ? ref_mem[addr[5:2]] : '0;
        base       = sub_valids;
        mgr_ar     = '{arvalid: 1'b1, araddr: addr, arprot: 3'b101};
        mgr_rready = (stall == 0);
        @(negedge axi_m);
        while (!mgr_arready) @(negedge axi_m);
        @(posedge axi_m);
        #2 mgr_ar.arvalid = 1'b0;
        @(negedge axi_m);
        while (!mgr_r.rvalid) @(negedge axi_m);
        held = mgr_r;
        // Read queued to the next window waits behind the stalled response
        if (stall > 0) begin
            @(posedge axi_m);
            #2 mgr_ar = '{arvalid: 1'b1, araddr: neighbor_addr(addr), arprot: 3'b101};
            repeat (stall) begin
                @(negedge axi_m);
                check("mgr_r", 64'(mgr_r), 64'(held));
                check("mgr_arready", 64'(mgr_arready), 64'h0);
            end
            @(posedge axi_m);
            #2 mgr_rready = 1'b1;
        end
        @(posedge axi_m);
        #2 mgr_rready = 1'b0;
        check("rdata", 64'(held.rdata), 64'(exp_data));
        check("rresp", 64'(held.rresp), 64'(exp_resp));
        if (exp_resp == DECERR) check("sub valid count", 64'(sub_valids), 64'(base));
    endtask

    ////////////////////
    // Test sequence from the data file
    initial begin
        int k;
        void'($urandom(91115));
        axi_m      = 1'b0;
        rst_n      = 1'b0;
        mgr_aw     = '0;
        mgr_w      = '0;
        mgr_ar     = '0;
        mgr_bready = 1'b0;
        mgr_rready = 1'b0;
        errors     = 0;
        sub_valids = 0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < MAX_ACC*4; i++) begin
            stim[i] = '1;
        end
        $readmemh("axi_lite_demux_testdata.txt", stim);
        num_acc = 0;
        while (num_acc < MAX_ACC && stim[4*num_acc] != '1) num_acc++;
        repeat (4) @(posedge axi_m);
        #2 rst_n = 1'b1;
        k = 0;
        while (k < num_acc) begin
            case (stim[4*k])
                0: write_access(stim[4*k+1], stim[4*k+2], stim[4*k+3][3:0], 0);
                1: read_access(stim[4*k+1], 0);
                // Stalled access, then the one queued behind it
                2: begin
                    write_access(stim[4*k+1], stim[4*k+2], stim[4*k+3][3:0],
                                 $urandom_range(6, 2));
                    write_access(neighbor_addr(stim[4*k+1]), stim[4*k+2],
                                 stim[4*k+3][3:0], 0);
                end
                3: begin
                    read_access(stim[4*k+1], $urandom_range(6, 2));
                    read_access(neighbor_addr(stim[4*k+1]), 0);
                end
                // Write together with the read on the next line
                4: begin
                    fork
                        write_access(stim[4*k+1], stim[4*k+2], stim[4*k+3][3:0], 0);
                        read_access(stim[4*k+5], 0);
                    join
                    k++;
                end
                default: begin
                    $display("Unknown operation %0h on test data entry %0d", stim[4*k], k);
                    errors++;
                end
            endcase
            k++;
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the number of accesses
    initial begin
        #1;
        repeat ((num_acc + 10) * 40) @(posedge axi_m);
        $display("Watchdog expired, the accesses did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
